/* compile.f */
+incdir+verilog
verilog/axi_upsize_pkg.sv
verilog/axi_upsize_ifs.sv
verilog/ar_burst_converter.sv
verilog/r_beat_splitter.sv
verilog/r_skid_output.sv
verilog/axi_rd_upsizer.sv
bench/tb_clock_gen.sv
bench/tb_axi_rd_upsizer.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_axi_rd_upsizer -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi

/* bench/tb_axi_rd_upsizer.sv */
// AXI read upsizer testbench with a 64-bit memory model, a reference beat model and a beat checker
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_upsizer;
    import axi_upsize_pkg::*;

    localparam burst_t BURST_INCR = 2'b01;
    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    // slave beats per test are 8, 5, 4, 16 and 8
    localparam int TIMEOUT_CYCLES = (8 + 5 + 4 + 16 + 8) * 4 + 5 * 20;

    logic clk;
    logic rst;
    id_t s_arid;
    addr_t s_araddr;
    len_t s_arlen;
    size_t s_arsize;
    burst_t s_arburst;
    cache_t s_arcache;
    prot_t s_arprot;
    logic s_arvalid;
    logic s_arready;
    id_t s_rid;
    s_data_t s_rdata;
    resp_t s_rresp;
    logic s_rlast;
    logic s_rvalid;
    logic s_rready = 1'b0;
    id_t m_arid;
    addr_t m_araddr;
    len_t m_arlen;
    size_t m_arsize;
    burst_t m_arburst;
    cache_t m_arcache;
    prot_t m_arprot;
    logic m_arvalid;
    logic m_arready = 1'b0;
    m_data_t m_rdata = '0;
    resp_t m_rresp = '0;
    logic m_rlast = 1'b0;
    logic m_rvalid = 1'b0;
    logic m_rready;

    // memory model state
    logic mem_busy = 1'b0;
    addr_t mem_addr = '0;
    len_t mem_len = '0;
    size_t mem_size = '0;
    burst_t mem_burst = '0;
    logic [8:0] issued = '0;
    addr_t mem_beat_addr;
    addr_t mem_word_addr;

    // current burst as seen by the checker
    id_t cur_id;
    addr_t cur_addr;
    len_t cur_len;
    size_t cur_size;
    burst_t cur_burst;
    cache_t cur_cache;
    prot_t cur_prot;
    len_t cur_exp_mlen;
    size_t cur_exp_msize;
    int beat_base;
    logic stall_on;
    logic in_burst = 1'b0;
    int rx_total = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [38:0] exp_beat;
    logic [31:0] lfsr = 32'h989e;
    logic [31:0] lfsr_next;

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));

    axi_rd_upsizer UUT (
        .clk(clk), .rst(rst),
        .s_arid(s_arid), .s_araddr(s_araddr), .s_arlen(s_arlen), .s_arsize(s_arsize),
        .s_arburst(s_arburst), .s_arcache(s_arcache), .s_arprot(s_arprot),
        .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rid(s_rid), .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rlast(s_rlast),
        .s_rvalid(s_rvalid), .s_rready(s_rready),
        .m_arid(m_arid), .m_araddr(m_araddr), .m_arlen(m_arlen), .m_arsize(m_arsize),
        .m_arburst(m_arburst), .m_arcache(m_arcache), .m_arprot(m_arprot),
        .m_arvalid(m_arvalid), .m_arready(m_arready),
        .m_rdata(m_rdata), .m_rresp(m_rresp), .m_rlast(m_rlast),
        .m_rvalid(m_rvalid), .m_rready(m_rready)
    );

    function automatic logic [31:0] mem_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'hc0de0000;
    endfunction

    function automatic logic in_error_range(addr_t a);
        return (a >= 32'h8000) && (a <= 32'h80ff);
    endfunction

    // the first AXI beat sits at the start address and later beats are aligned to the size
    function automatic addr_t beat_address(addr_t start, size_t size, burst_t burst, int idx);
        addr_t aligned;
        aligned = start & ~((addr_t'(1) << size) - addr_t'(1));
        if (burst != BURST_INCR || idx == 0)
            return start;
        return aligned + (addr_t'(idx) << size);
    endfunction

    // expected slave beat as {rid, rresp, rlast, rdata}
    function automatic logic [38:0] expected_beat(id_t id, addr_t addr, len_t len, size_t size,
            burst_t burst, int idx);
        addr_t a;
        resp_t resp;
        a = beat_address(addr, size, burst, idx);
        resp = in_error_range(a) ? RESP_SLVERR : RESP_OKAY;
        return {id, resp, idx == int'(len), mem_word(a)};
    endfunction

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // 64-bit memory that gives one beat per cycle whenever the master is ready
    always @(posedge clk) begin
        if (rst) begin
            m_arready <= 1'b0;
            m_rvalid <= 1'b0;
            m_rlast <= 1'b0;
            mem_busy <= 1'b0;
        end else begin
            m_arready <= 1'b1;
            if (m_arvalid && m_arready) begin
                mem_busy <= 1'b1;
                mem_addr <= m_araddr;
                mem_len <= m_arlen;
                mem_size <= m_arsize;
                mem_burst <= m_arburst;
                issued <= '0;
            end else if (mem_busy && (!m_rvalid || m_rready)) begin
                if (issued > {1'b0, mem_len}) begin
                    m_rvalid <= 1'b0;
                    m_rlast <= 1'b0;
                    mem_busy <= 1'b0;
                end else begin
                    mem_beat_addr = beat_address(mem_addr, mem_size, mem_burst, int'(issued));
                    mem_word_addr = {mem_beat_addr[31:3], 3'b000};
                    m_rvalid <= 1'b1;
                    m_rdata <= {mem_word(mem_word_addr + 32'd4), mem_word(mem_word_addr)};
                    m_rresp <= in_error_range(mem_beat_addr) ? RESP_SLVERR : RESP_OKAY;
                    m_rlast <= (issued == {1'b0, mem_len});
                    issued <= issued + 9'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            s_rready <= 1'b0;
        end else if (stall_on) begin
            lfsr_next = lfsr_step(lfsr);
            lfsr <= lfsr_next;
            s_rready <= lfsr_next[0];
        end else begin
            s_rready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (m_arvalid && m_arready) begin
                compare_value("m_araddr", 64'(m_araddr), 64'(cur_addr));
                compare_value("m_arlen", 64'(m_arlen), 64'(cur_exp_mlen));
                compare_value("m_arsize", 64'(m_arsize), 64'(cur_exp_msize));
                compare_value("m_arburst", 64'(m_arburst), 64'(cur_burst));
                compare_value("m_arcache", 64'(m_arcache), 64'(cur_cache));
                compare_value("m_arprot", 64'(m_arprot), 64'(cur_prot));
                compare_value("m_arid", 64'(m_arid), 64'd0);
            end
            if (s_arvalid && s_arready)
                in_burst <= 1'b1;
            // no new address may be taken before the final beat of the burst in flight
            if (in_burst && !stall_on && s_arready && !(s_rvalid && s_rlast)) begin
                errors++;
                $display("s_arready went high before the final beat at cycle %0d", cycles);
            end
            if (s_rvalid && s_rready) begin
                exp_beat = expected_beat(cur_id, cur_addr, cur_len, cur_size, cur_burst,
                    rx_total - beat_base);
                compare_value("s_rid", 64'(s_rid), 64'(exp_beat[38:35]));
                compare_value("s_rresp", 64'(s_rresp), 64'(exp_beat[34:33]));
                compare_value("s_rlast", 64'(s_rlast), 64'(exp_beat[32]));
                compare_value("s_rdata", 64'(s_rdata), 64'(exp_beat[31:0]));
                if (s_rlast)
                    in_burst <= 1'b0;
                rx_total <= rx_total + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic send_address(input id_t id, input addr_t addr, input len_t len,
            input size_t size, input burst_t burst, input cache_t cache, input prot_t prot);
        @(posedge clk);
        s_arid <= id;
        s_araddr <= addr;
        s_arlen <= len;
        s_arsize <= size;
        s_arburst <= burst;
        s_arcache <= cache;
        s_arprot <= prot;
        s_arvalid <= 1'b1;
        @(posedge clk);
        while (!s_arready)
            @(posedge clk);
        s_arvalid <= 1'b0;
    endtask

    task automatic run_test(input int num, input string name, input id_t id, input addr_t addr,
            input len_t len, input size_t size, input burst_t burst, input cache_t cache,
            input logic stall);
        int errors_before;
        logic convert;
        addr_t end_addr;
        errors_before = errors;
        convert = (burst == BURST_INCR) && cache[1] && (size == 3'd2);
        // address of the last byte that the slave beats cover
        end_addr = addr + ((addr_t'(len) + addr_t'(1)) << size) - addr_t'(1);
        cur_id = id;
        cur_addr = addr;
        cur_len = len;
        cur_size = size;
        cur_burst = burst;
        cur_cache = cache;
        cur_prot = prot_t'(num);
        // a converted burst reads every 64-bit word from the first to the last byte
        cur_exp_mlen = convert ? len_t'((end_addr >> 3) - (addr >> 3)) : len;
        cur_exp_msize = convert ? 3'd3 : size;
        beat_base = rx_total;
        stall_on <= stall;
        send_address(id, addr, len, size, burst, cache, cur_prot);
        while (rx_total - beat_base <= int'(len))
            @(posedge clk);
        stall_on <= 1'b0;
        if (errors == errors_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    endtask

    initial begin
        s_arid = '0;
        s_araddr = '0;
        s_arlen = '0;
        s_arsize = '0;
        s_arburst = '0;
        s_arcache = '0;
        s_arprot = '0;
        s_arvalid = 1'b0;
        stall_on = 1'b0;
        beat_base = 0;
        @(posedge clk);
        while (rst)
            @(posedge clk);

        run_test(1, "aligned converted burst", 4'h1, 32'h100, 8'd7, 3'd2, BURST_INCR, 4'h2, 1'b0);
        run_test(2, "unaligned converted burst", 4'h2, 32'h104, 8'd4, 3'd2, BURST_INCR, 4'h2,
            1'b0);
        run_test(3, "narrow pass-through", 4'h3, 32'h304, 8'd3, 3'd2, BURST_INCR, 4'h0, 1'b0);
        run_test(4, "random back-pressure", 4'h4, 32'h200, 8'd15, 3'd2, BURST_INCR, 4'h3, 1'b1);
        run_test(5, "error responses", 4'h5, 32'h7ff4, 8'd7, 3'd2, BURST_INCR, 4'h2, 1'b0);

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// testbench clock and reset source: 8 ns clock, reset held for the first four cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* verilog/axi_rd_upsizer.sv */
// AXI4 read upsizer top: 32-bit slave port served by a 64-bit master port
`timescale 1ns/1ps
`default_nettype none

`include "axi_upsize_settings.svh"

module axi_rd_upsizer (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_upsize_pkg::id_t     s_arid,
    input  axi_upsize_pkg::addr_t   s_araddr,
    input  axi_upsize_pkg::len_t    s_arlen,
    input  axi_upsize_pkg::size_t   s_arsize,
    input  axi_upsize_pkg::burst_t  s_arburst,
    input  axi_upsize_pkg::cache_t  s_arcache,
    input  axi_upsize_pkg::prot_t   s_arprot,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output axi_upsize_pkg::id_t     s_rid,
    output axi_upsize_pkg::s_data_t s_rdata,
    output axi_upsize_pkg::resp_t   s_rresp,
    output logic                    s_rlast,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output axi_upsize_pkg::id_t     m_arid,
    output axi_upsize_pkg::addr_t   m_araddr,
    output axi_upsize_pkg::len_t    m_arlen,
    output axi_upsize_pkg::size_t   m_arsize,
    output axi_upsize_pkg::burst_t  m_arburst,
    output axi_upsize_pkg::cache_t  m_arcache,
    output axi_upsize_pkg::prot_t   m_arprot,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    input  axi_upsize_pkg::m_data_t m_rdata,
    input  axi_upsize_pkg::resp_t   m_rresp,
    input  logic                    m_rlast,
    input  logic                    m_rvalid,
    output logic                    m_rready
);

    // the splitter only handles two slave beats per master word
    if (`AXU_M_DATA_W != 2 * `AXU_S_DATA_W) begin : g_width_check
        $fatal(1, "master data width must be twice the slave data width");
    end

    burst_if burst_bus ();
    beat_if  beat_bus ();

    ar_burst_converter u_conv (
        .clk(clk), .rst(rst),
        .s_arid(s_arid), .s_araddr(s_araddr), .s_arlen(s_arlen), .s_arsize(s_arsize),
        .s_arburst(s_arburst), .s_arcache(s_arcache), .s_arprot(s_arprot),
        .s_arvalid(s_arvalid), .s_arready(s_arready),
        .m_arid(m_arid), .m_araddr(m_araddr), .m_arlen(m_arlen), .m_arsize(m_arsize),
        .m_arburst(m_arburst), .m_arcache(m_arcache), .m_arprot(m_arprot),
        .m_arvalid(m_arvalid), .m_arready(m_arready),
        .burst(burst_bus)
    );

    r_beat_splitter u_split (
        .clk(clk), .rst(rst),
        .m_rdata(m_rdata), .m_rresp(m_rresp), .m_rlast(m_rlast),
        .m_rvalid(m_rvalid), .m_rready(m_rready),
        .burst(burst_bus), .beat(beat_bus)
    );

    r_skid_output u_out (
        .clk(clk), .rst(rst), .beat(beat_bus),
        .s_rid(s_rid), .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rlast(s_rlast),
        .s_rvalid(s_rvalid), .s_rready(s_rready)
    );

endmodule

`default_nettype wire

/* verilog/r_skid_output.sv */
// AXI read output stage: registered slave R channel with one temporary entry
`timescale 1ns/1ps
`default_nettype none

module r_skid_output (
    input  logic                    clk,
    input  logic                    rst,
    beat_if.dst                     beat,
    output axi_upsize_pkg::id_t     s_rid,
    output axi_upsize_pkg::s_data_t s_rdata,
    output axi_upsize_pkg::resp_t   s_rresp,
    output logic                    s_rlast,
    output logic                    s_rvalid,
    input  logic                    s_rready
);
    import axi_upsize_pkg::*;

    id_t     temp_id;
    s_data_t temp_data;
    resp_t   temp_resp;
    logic    temp_last;
    logic    temp_valid;
    logic    out_valid_next;
    logic    temp_valid_next;
    logic    in_to_out;
    logic    in_to_temp;
    logic    temp_to_out;
    logic    ready;

    // room next cycle unless the temp entry is full or about to fill
    assign beat.ready_early = s_rready || (!temp_valid && (!s_rvalid || !beat.valid));
    assign beat.ready = ready;

    always_comb begin
        out_valid_next = s_rvalid;
        temp_valid_next = temp_valid;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (ready) begin
            if (s_rready || !s_rvalid) begin
                out_valid_next = beat.valid;
                in_to_out = 1'b1;
            end else begin
                temp_valid_next = beat.valid;
                in_to_temp = 1'b1;
            end
        end else if (s_rready) begin
            // drain the temp entry behind the beat just taken
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_rvalid <= 1'b0;
            temp_valid <= 1'b0;
            ready <= 1'b0;
        end else begin
            s_rvalid <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready <= beat.ready_early;
        end

        if (in_to_out) begin
            s_rid <= beat.id;
            s_rdata <= beat.data;
            s_rresp <= beat.resp;
            s_rlast <= beat.last;
        end else if (temp_to_out) begin
            s_rid <= temp_id;
            s_rdata <= temp_data;
            s_rresp <= temp_resp;
            s_rlast <= temp_last;
        end
        if (in_to_temp) begin
            temp_id <= beat.id;
            temp_data <= beat.data;
            temp_resp <= beat.resp;
            temp_last <= beat.last;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rlast))
        else $error("stalled slave beat changed before it was taken");

endmodule

`default_nettype wire

/* verilog/r_beat_splitter.sv */
// AXI read beat splitter: turns 64-bit master beats into 32-bit slave beats
`timescale 1ns/1ps
`default_nettype none

`include "axi_upsize_settings.svh"

module r_beat_splitter (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_upsize_pkg::m_data_t m_rdata,
    input  axi_upsize_pkg::resp_t   m_rresp,
    input  logic                    m_rlast,
    input  logic                    m_rvalid,
    output logic                    m_rready,
    burst_if.split                  burst,
    beat_if.src                     beat
);
    import axi_upsize_pkg::*;

    split_state_t state;
    split_state_t state_next;
    addr_t        addr;
    addr_t        addr_next;
    len_t         count;
    len_t         count_next;
    size_t        size;
    id_t          id;
    m_data_t      word;
    resp_t        word_resp;
    logic         m_rready_next;
    logic         load_word;
    logic         beat_taken;

    function automatic s_data_t pick_half(m_data_t w, logic hi);
        return hi ? w[`AXU_M_DATA_W-1:`AXU_S_DATA_W] : w[`AXU_S_DATA_W-1:0];
    endfunction

    assign beat_taken = m_rready && m_rvalid;
    assign beat.id = id;

    always_comb begin
        state_next = state;
        addr_next = addr;
        count_next = count;
        m_rready_next = 1'b0;
        load_word = 1'b0;
        burst.done = 1'b0;
        beat.valid = 1'b0;
        beat.data = pick_half(m_rdata, addr[`AXU_S_SIZE]);
        beat.resp = m_rresp;
        beat.last = m_rlast;

        case (state)
            ST_IDLE: begin
                if (burst.start) begin
                    state_next = burst.convert ? ST_READ : ST_PASS;
                    addr_next = burst.addr;
                    count_next = burst.len;
                    m_rready_next = beat.ready_early;
                end
            end
            ST_PASS: begin
                m_rready_next = beat.ready_early;
                if (beat_taken) begin
                    beat.valid = 1'b1;
                    addr_next = addr + (addr_t'(1) << size);
                    if (m_rlast) begin
                        m_rready_next = 1'b0;
                        burst.done = 1'b1;
                        state_next = ST_IDLE;
                    end
                end
            end
            ST_READ: begin
                m_rready_next = beat.ready_early;
                if (beat_taken) begin
                    beat.valid = 1'b1;
                    beat.last = (count == '0);
                    load_word = 1'b1;
                    addr_next = addr + (addr_t'(1) << size);
                    count_next = count - 1'b1;
                    if (count == '0) begin
                        m_rready_next = 1'b0;
                        burst.done = 1'b1;
                        state_next = ST_IDLE;
                    end else if (addr_next[`AXU_M_SIZE] == addr[`AXU_M_SIZE]) begin
                        // upper half still waiting in the stored word
                        m_rready_next = 1'b0;
                        state_next = ST_SPLIT;
                    end
                end
            end
            ST_SPLIT: begin
                if (beat.ready) begin
                    beat.valid = 1'b1;
                    beat.data = pick_half(word, addr[`AXU_S_SIZE]);
                    beat.resp = word_resp;
                    beat.last = (count == '0);
                    addr_next = addr + (addr_t'(1) << size);
                    count_next = count - 1'b1;
                    if (count == '0) begin
                        burst.done = 1'b1;
                        state_next = ST_IDLE;
                    end else begin
                        m_rready_next = beat.ready_early;
                        state_next = ST_READ;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            m_rready <= 1'b0;
        end else begin
            state <= state_next;
            m_rready <= m_rready_next;
        end

        addr <= addr_next;
        count <= count_next;
        if (burst.start) begin
            size <= burst.size;
            id <= burst.id;
        end
        if (load_word) begin
            word <= m_rdata;
            word_resp <= m_rresp;
        end
    end

    assert property (@(posedge clk) disable iff (rst) beat.valid |-> beat.ready)
        else $error("beat offered while the output stage was not ready");

endmodule

`default_nettype wire

/* verilog/ar_burst_converter.sv */
// AXI read address converter that accepts slave bursts and issues the master burst
`timescale 1ns/1ps
`default_nettype none

`include "axi_upsize_settings.svh"

module ar_burst_converter (
    input  logic                     clk,
    input  logic                     rst,
    input  axi_upsize_pkg::id_t      s_arid,
    input  axi_upsize_pkg::addr_t    s_araddr,
    input  axi_upsize_pkg::len_t     s_arlen,
    input  axi_upsize_pkg::size_t    s_arsize,
    input  axi_upsize_pkg::burst_t   s_arburst,
    input  axi_upsize_pkg::cache_t   s_arcache,
    input  axi_upsize_pkg::prot_t    s_arprot,
    input  logic                     s_arvalid,
    output logic                     s_arready,
    output axi_upsize_pkg::id_t      m_arid,
    output axi_upsize_pkg::addr_t    m_araddr,
    output axi_upsize_pkg::len_t     m_arlen,
    output axi_upsize_pkg::size_t    m_arsize,
    output axi_upsize_pkg::burst_t   m_arburst,
    output axi_upsize_pkg::cache_t   m_arcache,
    output axi_upsize_pkg::prot_t    m_arprot,
    output logic                     m_arvalid,
    input  logic                     m_arready,
    burst_if.conv                    burst
);
    import axi_upsize_pkg::*;

    localparam burst_t BURST_INCR = 2'b01;

    logic       accept;
    logic       busy;
    logic       convert;
    logic [8:0] len_sum;

    assign accept = s_arvalid && s_arready;

    // only modifiable full-width INCR bursts may be re-packed
    assign convert = (s_arburst == BURST_INCR) && s_arcache[1]
        && (s_arsize == size_t'(`AXU_S_SIZE));

    // a start in the upper half costs one more slave beat in the first master word
    assign len_sum = {1'b0, s_arlen} + 9'(s_araddr[`AXU_S_SIZE]);

    assign burst.start   = accept;
    assign burst.addr    = s_araddr;
    assign burst.len     = s_arlen;
    assign burst.size    = s_arsize;
    assign burst.id      = s_arid;
    assign burst.convert = convert;

    assign m_arid = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            s_arready <= 1'b0;
            m_arvalid <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
            s_arready <= 1'b0;
            m_arvalid <= 1'b1;
        end else begin
            m_arvalid <= m_arvalid && !m_arready;
            // reopen once the last slave beat has left the splitter
            if (!busy || burst.done) begin
                busy <= 1'b0;
                s_arready <= !m_arvalid;
            end
        end

        if (accept) begin
            m_araddr <= s_araddr;
            m_arlen <= convert ? len_sum[8:1] : s_arlen;
            m_arsize <= convert ? size_t'(`AXU_M_SIZE) : s_arsize;
            m_arburst <= s_arburst;
            m_arcache <= s_arcache;
            m_arprot <= s_arprot;
        end
    end

    // a pending master address holds still until the memory side takes it
    assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arlen))
        else $error("master read address changed or dropped before arready");

endmodule

`default_nettype wire

/* verilog/axi_upsize_ifs.sv */
// AXI read upsizer internal buses: burst descriptor and slave beat channels
`timescale 1ns/1ps
`default_nettype none

interface burst_if;
    import axi_upsize_pkg::*;

    // descriptor fields are valid in the cycle of start
    logic   start;
    addr_t  addr;
    len_t   len;
    size_t  size;
    id_t    id;
    logic   convert;
    logic   done;

    modport conv (output start, addr, len, size, id, convert, input done);
    modport split (input start, addr, len, size, id, convert, output done);

endinterface

interface beat_if;
    import axi_upsize_pkg::*;

    s_data_t data;
    resp_t   resp;
    logic    last;
    id_t     id;
    logic    valid;
    // ready_early is combinational, ready is its registered copy
    logic    ready_early;
    logic    ready;

    modport src (output data, resp, last, id, valid, input ready_early, ready);
    modport dst (input data, resp, last, id, valid, output ready_early, ready);

endinterface

`default_nettype wire

/* verilog/axi_upsize_pkg.sv */
// AXI read upsizer package: shared vector types and the beat splitter state encoding
`default_nettype none

`include "axi_upsize_settings.svh"

package axi_upsize_pkg;

    typedef logic [`AXU_ADDR_W-1:0] addr_t;
    typedef logic [`AXU_ID_W-1:0] id_t;
    typedef logic [`AXU_S_DATA_W-1:0] s_data_t;
    typedef logic [`AXU_M_DATA_W-1:0] m_data_t;

    // AXI4 address channel fields
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [1:0] resp_t;
    typedef logic [3:0] cache_t;
    typedef logic [2:0] prot_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_PASS  = 2'd1,
        ST_READ  = 2'd2,
        ST_SPLIT = 2'd3
    } split_state_t;

endpackage

`default_nettype wire

/* verilog/axi_upsize_settings.svh */
// AXI read upsizer settings: bus widths and full-width transfer size codes
`ifndef AXI_UPSIZE_SETTINGS_SVH
`define AXI_UPSIZE_SETTINGS_SVH

// byte address and transaction id
`define AXU_ADDR_W 32
`define AXU_ID_W 4

// slave and master data buses
`define AXU_S_DATA_W 32
`define AXU_M_DATA_W 64

// log2 of the bytes per beat at full width on each side
`define AXU_S_SIZE 2
`define AXU_M_SIZE 3

`endif
